//--- logic/loader_pkg.sv
`default_nettype none

package loader_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int ADDR_W  = 27;
	localparam int HALF_W  = 16;
	localparam int WORD_W  = 32;
	localparam int INDEX_W = 8;

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [HALF_W-1:0]  half_t;
	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [INDEX_W-1:0] index_t;

	// ==================================================
	// Host download indices and RAM placement
	// ==================================================
	localparam index_t IDX_BIOS  = 8'd0;
	localparam index_t IDX_EXE   = 8'd1;
	localparam index_t IDX_CHEAT = 8'd255;

	// Byte offsets into main RAM
	localparam addr_t BIOS_BASE = 27'h020_0000;
	localparam addr_t EXE_BASE  = 27'h040_0000;

	// Cycles the core may run after a resume request
	localparam int UNPAUSE_HOLD = 1023;

	// Cheat code layout, bits 127:0 from flags down to replace
	typedef struct packed {
		word_t flags;
		word_t address;
		word_t compare;
		word_t replace;
	} cheat_code_t;

endpackage

`default_nettype wire

//--- logic/download_decode.sv
`default_nettype none

module download_decode (
	input  logic                  clk_1x,
	input  logic                  rst,
	input  logic                  ioctl_download,
	input  loader_pkg::index_t    ioctl_index,
	output logic                  bios_active,
	output logic                  exe_active,
	output logic                  cheat_active,
	output logic                  core_reset,
	output logic                  exe_loaded,
	output logic                  cheat_clear
);

	import loader_pkg::*;

	// Previous flag values for edge detection
	logic exe_active_q;
	logic cheat_active_q;

	// Kind flags, one cycle behind the host
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			bios_active  <= 1'b0;
			exe_active   <= 1'b0;
			cheat_active <= 1'b0;
		end else begin
			bios_active  <= ioctl_download & (ioctl_index == IDX_BIOS);
			exe_active   <= ioctl_download & (ioctl_index == IDX_EXE);
			cheat_active <= ioctl_download & (ioctl_index == IDX_CHEAT);
		end
	end

	// Executable end and cheat start pulses
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			exe_active_q   <= 1'b0;
			cheat_active_q <= 1'b0;
			exe_loaded     <= 1'b0;
			cheat_clear    <= 1'b0;
		end else begin
			exe_active_q   <= exe_active;
			cheat_active_q <= cheat_active;
			exe_loaded     <= exe_active_q & ~exe_active;
			cheat_clear    <= cheat_active & ~cheat_active_q;
		end
	end

	// Core stays in reset while its memory image is being replaced
	assign core_reset = bios_active | exe_active;

endmodule

`default_nettype wire

//--- logic/ram_write_packer.sv
`default_nettype none

module ram_write_packer (
	input  logic               clk_1x,
	input  logic               rst,
	input  logic               bios_active,
	input  logic               exe_active,
	input  logic               ioctl_wr,
	input  loader_pkg::addr_t  ioctl_addr,
	input  loader_pkg::half_t  ioctl_dout,
	input  logic               ram_ack,
	output logic               ioctl_wait,
	output logic               ram_wr,
	output loader_pkg::addr_t  ram_addr,
	output loader_pkg::word_t  ram_data
);

	import loader_pkg::*;

	logic  ram_active;
	addr_t kind_base;
	logic  strobe;

	assign ram_active = bios_active | exe_active;
	assign kind_base  = bios_active ? BIOS_BASE : EXE_BASE;
	assign strobe     = ram_active & ioctl_wr;

	// ==================================================
	// Halfword packing
	// ==================================================
	// Low half fixes the word address, high half completes the word
	always_ff @(posedge clk_1x) begin
		if (strobe) begin
			if (!ioctl_addr[1]) begin
				ram_data[HALF_W-1:0] <= ioctl_dout;
				ram_addr             <= ioctl_addr + kind_base;
			end else begin
				ram_data[WORD_W-1:HALF_W] <= ioctl_dout;
			end
		end
	end

	// ==================================================
	// Write strobe and host flow control
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			ram_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			ram_wr <= 1'b0;
			if (!ram_active) begin
				// Download gone, nothing left to wait for
				ioctl_wait <= 1'b0;
			end else begin
				if (ram_ack)
					ioctl_wait <= 1'b0;
				// Host never strobes while waiting, so one write in flight at most
				if (strobe && ioctl_addr[1]) begin
					ram_wr     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/cheat_code_assembler.sv
`default_nettype none

module cheat_code_assembler (
	input  logic                    clk_1x,
	input  logic                    rst,
	input  logic                    cheat_active,
	input  logic                    ioctl_wr,
	input  loader_pkg::addr_t       ioctl_addr,
	input  loader_pkg::half_t       ioctl_dout,
	output loader_pkg::cheat_code_t cheat_code,
	output logic                    cheat_valid
);

	import loader_pkg::*;

	logic       strobe;
	logic [3:0] slot;

	assign strobe = cheat_active & ioctl_wr;
	// Byte offset within the 16-byte code record
	assign slot   = ioctl_addr[3:0];

	// Each halfword lands in its own slice of the code
	always_ff @(posedge clk_1x) begin
		if (strobe) begin
			case (slot)
				4'd0:  cheat_code.flags[HALF_W-1:0]        <= ioctl_dout;
				4'd2:  cheat_code.flags[WORD_W-1:HALF_W]   <= ioctl_dout;
				4'd4:  cheat_code.address[HALF_W-1:0]      <= ioctl_dout;
				4'd6:  cheat_code.address[WORD_W-1:HALF_W] <= ioctl_dout;
				4'd8:  cheat_code.compare[HALF_W-1:0]      <= ioctl_dout;
				4'd10: cheat_code.compare[WORD_W-1:HALF_W] <= ioctl_dout;
				4'd12: cheat_code.replace[HALF_W-1:0]      <= ioctl_dout;
				4'd14: cheat_code.replace[WORD_W-1:HALF_W] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last halfword of a record hands the code to the core
	always_ff @(posedge clk_1x) begin
		if (rst)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= strobe & (slot == 4'd14);
	end

endmodule

`default_nettype wire

//--- logic/pause_control.sv
`default_nettype none

module pause_control (
	input  logic clk_1x,
	input  logic rst,
	input  logic pause_on_menu,
	input  logic menu_open,
	input  logic resume,
	output logic paused
);

	import loader_pkg::*;

	logic                                  resume_q;
	logic [$clog2(UNPAUSE_HOLD + 1)-1:0]   countdown;

	// Resume edge opens a run-on window under the open menu
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			resume_q  <= 1'b0;
			countdown <= '0;
		end else begin
			resume_q <= resume;
			if (resume && !resume_q)
				countdown <= UNPAUSE_HOLD[$bits(countdown)-1:0];
			else if (countdown != '0)
				countdown <= countdown - 1'b1;
		end
	end

	// Pause only with the menu up and no window running
	always_ff @(posedge clk_1x) begin
		if (rst)
			paused <= 1'b0;
		else
			paused <= pause_on_menu & menu_open & (countdown == '0);
	end

endmodule

`default_nettype wire

//--- logic/media_loader.sv
`default_nettype none

module media_loader (
	input  logic                    clk_1x,
	input  logic                    rst,
	// Host download port
	input  logic                    ioctl_download,
	input  loader_pkg::index_t      ioctl_index,
	input  loader_pkg::addr_t       ioctl_addr,
	input  logic                    ioctl_wr,
	input  loader_pkg::half_t       ioctl_dout,
	output logic                    ioctl_wait,
	// RAM write port
	output logic                    ram_wr,
	output loader_pkg::addr_t       ram_addr,
	output loader_pkg::word_t       ram_data,
	input  logic                    ram_ack,
	// Core controls
	output logic                    core_reset,
	output logic                    exe_loaded,
	output logic                    cheat_clear,
	output loader_pkg::cheat_code_t cheat_code,
	output logic                    cheat_valid,
	// Pause
	input  logic                    pause_on_menu,
	input  logic                    menu_open,
	input  logic                    resume,
	output logic                    paused
);

	logic bios_active;
	logic exe_active;
	logic cheat_active;

	download_decode u_download_decode (
		.clk_1x         (clk_1x),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.bios_active    (bios_active),
		.exe_active     (exe_active),
		.cheat_active   (cheat_active),
		.core_reset     (core_reset),
		.exe_loaded     (exe_loaded),
		.cheat_clear    (cheat_clear)
	);

	ram_write_packer u_ram_write_packer (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.bios_active (bios_active),
		.exe_active  (exe_active),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ram_ack     (ram_ack),
		.ioctl_wait  (ioctl_wait),
		.ram_wr      (ram_wr),
		.ram_addr    (ram_addr),
		.ram_data    (ram_data)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.cheat_active (cheat_active),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cheat_code   (cheat_code),
		.cheat_valid  (cheat_valid)
	);

	pause_control u_pause_control (
		.clk_1x        (clk_1x),
		.rst           (rst),
		.pause_on_menu (pause_on_menu),
		.menu_open     (menu_open),
		.resume        (resume),
		.paused        (paused)
	);

endmodule

`default_nettype wire

//--- tests/media_loader_tb.sv
`default_nettype none

module media_loader_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import loader_pkg::*;

	localparam time CLK_PERIOD  = 100ns;
	localparam time DRIVE_DELAY = 10ns;
	// Generous bound on the whole run in clock cycles
	localparam int  TEST_CYCLES = 10000;

	logic        clk_1x;
	logic        rst;
	logic        ioctl_download;
	index_t      ioctl_index;
	addr_t       ioctl_addr;
	logic        ioctl_wr;
	half_t       ioctl_dout;
	logic        ioctl_wait;
	logic        ram_wr;
	addr_t       ram_addr;
	word_t       ram_data;
	logic        ram_ack;
	logic        core_reset;
	logic        exe_loaded;
	logic        cheat_clear;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        pause_on_menu;
	logic        menu_open;
	logic        resume;
	logic        paused;

	int          checks;
	int          errors;
	int          ram_wr_count;
	int          exe_loaded_count;
	int          cheat_clear_count;
	int          cheat_valid_count;
	// Separate streams for host data and RAM ack delays
	logic [31:0] lcg_state;
	logic [31:0] ack_lcg_state;
	addr_t       expected_addr[$];
	word_t       expected_data[$];

	media_loader u_media_loader (.*);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] next_rand(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	task automatic compare_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_property(input string name, input logic expected, input logic actual);
		errors++;
		$display("CHECK FAILED: %s expected %b actual %b", name, expected, actual);
	endtask

	task automatic next_edge();
		@(posedge clk_1x);
		#DRIVE_DELAY;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (ioctl_wait && cycles < 20) begin
			next_edge();
			cycles++;
		end
		if (ioctl_wait) begin
			errors++;
			$display("Host gave up: ioctl_wait still high after %0d cycles", cycles);
		end
	endtask

	task automatic host_write(input addr_t addr, input half_t data);
		wait_ready();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		next_edge();
		ioctl_wr   = 1'b0;
	endtask

	task automatic start_download(input index_t index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		next_edge();
		next_edge();
	endtask

	// Sixteen halfwords from offset 0x100, pairs expected as RAM words
	task automatic load_image(input index_t index, input addr_t base, input logic to_ram);
		half_t low;
		half_t data;
		addr_t addr;
		int    wr_before;
		int    exe_before;
		wr_before  = ram_wr_count;
		exe_before = exe_loaded_count;
		start_download(index);
		for (int i = 0; i < 16; i++) begin
			addr = addr_t'(32'h100 + i * 2);
			data = half_t'(next_rand(lcg_state) >> 16);
			if (!addr[1])
				low = data;
			else if (to_ram) begin
				expected_addr.push_back(addr_t'(addr - 2 + base));
				expected_data.push_back({data, low});
			end
			compare_value("image_core_reset", to_ram, core_reset);
			host_write(addr, data);
		end
		wait_ready();
		ioctl_download = 1'b0;
		next_edge();
		next_edge();
		compare_value("exe_loaded_timing", index == IDX_EXE, exe_loaded);
		compare_value("core_reset_after", 0, core_reset);
		next_edge();
		compare_value("exe_loaded_count", (index == IDX_EXE) ? 1 : 0,
			exe_loaded_count - exe_before);
		compare_value("ram_wr_count", to_ram ? 8 : 0, ram_wr_count - wr_before);
	endtask

	task automatic load_cheat();
		cheat_code_t expected;
		half_t       data;
		int          wr_before;
		int          clear_before;
		int          valid_before;
		wr_before    = ram_wr_count;
		clear_before = cheat_clear_count;
		valid_before = cheat_valid_count;
		expected     = '0;
		start_download(IDX_CHEAT);
		for (int k = 0; k < 16; k += 2) begin
			data = half_t'(next_rand(lcg_state) >> 12);
			// Every 4 bytes moves one field down from flags, bit 1 picks the upper half
			expected[96 - 32 * (k / 4) + 16 * ((k / 2) % 2) +: 16] = data;
			host_write(addr_t'(k), data);
			compare_value("cheat_wait_low", 0, ioctl_wait);
		end
		compare_value("cheat_valid", 1, cheat_valid);
		compare_value("cheat_code", expected, cheat_code);
		ioctl_download = 1'b0;
		next_edge();
		next_edge();
		compare_value("cheat_clear_count", 1, cheat_clear_count - clear_before);
		compare_value("cheat_valid_count", 1, cheat_valid_count - valid_before);
		compare_value("cheat_ram_wr", 0, ram_wr_count - wr_before);
	endtask

	// ==================================================
	// Pulse counters and protocol properties
	// ==================================================
	always @(posedge clk_1x) begin
		if (rst) begin
			ram_wr_count      <= 0;
			exe_loaded_count  <= 0;
			cheat_clear_count <= 0;
			cheat_valid_count <= 0;
		end else begin
			if (ram_wr)
				ram_wr_count <= ram_wr_count + 1;
			if (exe_loaded)
				exe_loaded_count <= exe_loaded_count + 1;
			if (cheat_clear)
				cheat_clear_count <= cheat_clear_count + 1;
			if (cheat_valid)
				cheat_valid_count <= cheat_valid_count + 1;
		end
	end

	wait_after_wr: assert property (@(posedge clk_1x) disable iff (rst) ram_wr |-> ioctl_wait)
		else report_property("wait_after_wr", 1'b1, 1'b0);
	wait_holds: assert property (@(posedge clk_1x) disable iff (rst)
		(ioctl_wait && !ram_ack) |=> ioctl_wait)
		else report_property("wait_holds", 1'b1, 1'b0);
	wait_release: assert property (@(posedge clk_1x) disable iff (rst) ram_ack |=> !ioctl_wait)
		else report_property("wait_release", 1'b0, 1'b1);
	single_write: assert property (@(posedge clk_1x) disable iff (rst) ioctl_wait |=> !ram_wr)
		else report_property("single_write", 1'b0, 1'b1);

	// RAM model, acks each write 1 to 8 cycles later
	initial begin : ram_responder
		int delay;
		ack_lcg_state = 32'd42;
		ram_ack       = 1'b0;
		forever begin
			next_edge();
			if (ram_wr === 1'b1) begin
				if (expected_addr.size() == 0) begin
					errors++;
					$display("RAM write to %0h arrived when none was expected", ram_addr);
				end else begin
					compare_value("ram_addr", expected_addr.pop_front(), ram_addr);
					compare_value("ram_data", expected_data.pop_front(), ram_data);
				end
				delay = 1 + int'((next_rand(ack_lcg_state) >> 16) % 8);
				repeat (delay) next_edge();
				ram_ack = 1'b1;
				next_edge();
				ram_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: run still going at %0t, %0d errors so far", $time, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin : stimulus
		int   cycles;
		logic low_ok;
		int   clear_before;
		int   valid_before;
		lcg_state      = 32'd42;
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_wr       = 1'b0;
		ioctl_dout     = '0;
		pause_on_menu  = 1'b0;
		menu_open      = 1'b0;
		resume         = 1'b0;
		repeat (2) next_edge();
		rst = 1'b0;
		next_edge();
		compare_value("reset_outputs", 0,
			{ram_wr, ioctl_wait, exe_loaded, cheat_clear, cheat_valid, core_reset, paused});

		load_image(IDX_BIOS, BIOS_BASE, 1'b1);
		load_image(IDX_EXE, EXE_BASE, 1'b1);
		load_cheat();
		load_cheat();

		// Menu pause, then the run-on window after resume
		pause_on_menu = 1'b1;
		menu_open     = 1'b1;
		next_edge();
		next_edge();
		compare_value("pause_menu", 1, paused);
		resume = 1'b1;
		next_edge();
		next_edge();
		cycles = 2;
		low_ok = 1'b1;
		repeat (1000) begin
			if (paused)
				low_ok = 1'b0;
			next_edge();
			cycles++;
		end
		while (!paused && cycles < 1100) begin
			next_edge();
			cycles++;
		end
		compare_value("pause_run_on_low", 1, low_ok);
		compare_value("pause_returns_in_time", 1, paused && cycles <= 1030);
		resume    = 1'b0;
		menu_open = 1'b0;
		next_edge();
		next_edge();
		compare_value("pause_menu_closed", 0, paused);

		// Unknown index is ignored
		clear_before = cheat_clear_count;
		valid_before = cheat_valid_count;
		load_image(8'd7, '0, 1'b0);
		compare_value("unused_cheat_pulses", 0,
			(cheat_clear_count - clear_before) + (cheat_valid_count - valid_before));

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
logic/loader_pkg.sv
logic/download_decode.sv
logic/ram_write_packer.sv
logic/cheat_code_assembler.sv
logic/pause_control.sv
logic/media_loader.sv
tests/media_loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module media_loader_tb -o media_loader_sim \
	&& ./obj_dir/media_loader_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
